// File: hdl/rv32_core.sv
/*
 * RV32I core top level, one instruction in flight
 * Instances, retire condition and write-back select
 */
module rv32_core #(
  parameter rv32_pkg::word_t INITIAL_PC = '0
) (
  input  logic            clk,
  input  logic            reset,
  output logic            instr_req_o,
  output rv32_pkg::word_t instr_addr_o,
  input  logic            instr_ack_i,
  input  rv32_pkg::word_t instr_data_i,
  output logic            data_req_o,
  output logic            data_we_o,
  output rv32_pkg::word_t data_addr_o,
  output rv32_pkg::word_t data_wdata_o,
  input  logic            data_ack_i,
  input  rv32_pkg::word_t data_rdata_i
);

  rv32_pkg::word_t pc;
  rv32_pkg::word_t pc_next;
  rv32_pkg::word_t instr;
  logic            instr_valid;
  rv32_pkg::word_t rs1_data;
  rv32_pkg::word_t rs2_data;
  rv32_pkg::word_t alu_result;
  logic            redirect;
  rv32_pkg::word_t redirect_pc;
  logic            stall;
  rv32_pkg::word_t load_data;
  logic            retire;
  rv32_pkg::word_t wb_data;

  rv32_ctrl_if ctrl ();

  // Retire once the held instruction has no memory access left
  assign retire = instr_valid && !stall;

  // Write-back select
  always_comb begin
    case (ctrl.wb_src)
      rv32_pkg::WB_PC_NEXT: wb_data = pc_next;
      rv32_pkg::WB_LOAD:    wb_data = load_data;
      default:              wb_data = alu_result;
    endcase
  end

  rv32_fetch #(
    .INITIAL_PC(INITIAL_PC)
  ) u_fetch (
    .clk(clk), .reset(reset),
    .retire_i(retire), .redirect_i(redirect), .redirect_pc_i(redirect_pc),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o),
    .instr_ack_i(instr_ack_i), .instr_data_i(instr_data_i),
    .pc_o(pc), .pc_next_o(pc_next),
    .instr_o(instr), .instr_valid_o(instr_valid)
  );

  rv32_decoder u_decoder (.instr_i(instr), .ctrl(ctrl.dec));

  rv32_regfile u_regfile (
    .clk(clk), .reset(reset),
    .rs1_i(ctrl.rs1), .rs2_i(ctrl.rs2),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .rd_i(ctrl.rd), .rd_data_i(wb_data), .rd_we_i(ctrl.rd_write && retire)
  );

  rv32_execute u_execute (
    .ctrl(ctrl.exe), .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .alu_result_o(alu_result), .redirect_o(redirect), .redirect_pc_o(redirect_pc)
  );

  // Address from the ALU sum, store data from rs2
  rv32_lsu u_lsu (
    .clk(clk), .reset(reset), .ctrl(ctrl.lsu),
    .instr_valid_i(instr_valid), .addr_i(alu_result), .wdata_i(rs2_data),
    .stall_o(stall), .load_data_o(load_data),
    .data_req_o(data_req_o), .data_we_o(data_we_o),
    .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
    .data_ack_i(data_ack_i), .data_rdata_i(data_rdata_i)
  );

endmodule

// File: hdl/rv32_ctrl_if.sv
/*
 * Decoded control bundle
 * Driven by the decoder, read by execute, load/store and write-back
 */
interface rv32_ctrl_if;

  // Register indices and immediate
  rv32_pkg::reg_idx_t rs1;
  rv32_pkg::reg_idx_t rs2;
  rv32_pkg::reg_idx_t rd;
  rv32_pkg::word_t    imm;

  // Execute controls
  rv32_pkg::alu_op_t  alu_op;
  logic               op_a_is_pc;
  logic               op_b_is_imm;
  rv32_pkg::br_cond_t br_cond;
  logic               is_jalr;

  // Memory and write-back
  logic               mem_read;
  logic               mem_write;
  logic               rd_write;
  rv32_pkg::wb_src_t  wb_src;

  modport dec (output rs1, rs2, rd, imm, alu_op, op_a_is_pc, op_b_is_imm, br_cond,
               is_jalr, mem_read, mem_write, rd_write, wb_src);
  modport exe (input imm, alu_op, op_a_is_pc, op_b_is_imm, br_cond, is_jalr);
  modport lsu (input mem_read, mem_write);
  modport wb  (input rs1, rs2, rd, rd_write, wb_src);

endinterface

// File: hdl/rv32_decoder.sv
/*
 * Instruction decoder
 * Field split, I/S/B/U/J immediates and control decode
 */
module rv32_decoder (
  input  rv32_pkg::word_t instr_i,
  rv32_ctrl_if.dec        ctrl
);

  // Register-register and register-immediate ALU ops share funct3
  function automatic rv32_pkg::alu_op_t alu_from_funct3(
    input logic [2:0] funct3,
    input logic       sub_en,
    input logic       sra_en
  );
    rv32_pkg::alu_op_t op;
    case (funct3)
      3'b000:  op = sub_en ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
      3'b001:  op = rv32_pkg::ALU_SLL;
      3'b010:  op = rv32_pkg::ALU_SLT;
      3'b011:  op = rv32_pkg::ALU_SLTU;
      3'b100:  op = rv32_pkg::ALU_XOR;
      3'b101:  op = sra_en ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
      3'b110:  op = rv32_pkg::ALU_OR;
      default: op = rv32_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv32_pkg::word_t imm_i;
  rv32_pkg::word_t imm_s;
  rv32_pkg::word_t imm_b;
  rv32_pkg::word_t imm_u;
  rv32_pkg::word_t imm_j;

  // Fields
  assign funct3   = instr_i[14:12];
  assign funct7   = instr_i[31:25];
  assign ctrl.rs1 = instr_i[19:15];
  assign ctrl.rs2 = instr_i[24:20];
  assign ctrl.rd  = instr_i[11:7];

  // Sign-extended immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // Defaults form a no-op
    ctrl.imm         = imm_i;
    ctrl.alu_op      = rv32_pkg::ALU_ADD;
    ctrl.op_a_is_pc  = 1'b0;
    ctrl.op_b_is_imm = 1'b1;
    ctrl.br_cond     = rv32_pkg::BR_NONE;
    ctrl.is_jalr     = 1'b0;
    ctrl.mem_read    = 1'b0;
    ctrl.mem_write   = 1'b0;
    ctrl.rd_write    = 1'b0;
    ctrl.wb_src      = rv32_pkg::WB_ALU;
    case (rv32_pkg::opcode_t'(instr_i[6:0]))
      rv32_pkg::OPC_OP_IMM: begin
        // No SUB form, funct7 only picks SRAI
        ctrl.alu_op   = alu_from_funct3(funct3, 1'b0, funct7[5]);
        ctrl.rd_write = 1'b1;
      end
      rv32_pkg::OPC_OP: begin
        ctrl.alu_op      = alu_from_funct3(funct3, funct7[5], funct7[5]);
        ctrl.op_b_is_imm = 1'b0;
        ctrl.rd_write    = 1'b1;
      end
      rv32_pkg::OPC_LUI: begin
        ctrl.imm      = imm_u;
        ctrl.alu_op   = rv32_pkg::ALU_PASS_B;
        ctrl.rd_write = 1'b1;
      end
      rv32_pkg::OPC_AUIPC: begin
        ctrl.imm        = imm_u;
        ctrl.op_a_is_pc = 1'b1;
        ctrl.rd_write   = 1'b1;
      end
      rv32_pkg::OPC_JAL: begin
        ctrl.imm      = imm_j;
        ctrl.br_cond  = rv32_pkg::BR_ALWAYS;
        ctrl.rd_write = 1'b1;
        ctrl.wb_src   = rv32_pkg::WB_PC_NEXT;
      end
      rv32_pkg::OPC_JALR: begin
        ctrl.br_cond  = rv32_pkg::BR_ALWAYS;
        ctrl.is_jalr  = 1'b1;
        ctrl.rd_write = 1'b1;
        ctrl.wb_src   = rv32_pkg::WB_PC_NEXT;
      end
      rv32_pkg::OPC_BRANCH: begin
        ctrl.imm         = imm_b;
        ctrl.op_b_is_imm = 1'b0;
        case (funct3)
          3'b000:  ctrl.br_cond = rv32_pkg::BR_EQ;
          3'b001:  ctrl.br_cond = rv32_pkg::BR_NE;
          3'b100:  ctrl.br_cond = rv32_pkg::BR_LT;
          3'b101:  ctrl.br_cond = rv32_pkg::BR_GE;
          3'b110:  ctrl.br_cond = rv32_pkg::BR_LTU;
          3'b111:  ctrl.br_cond = rv32_pkg::BR_GEU;
          default: ctrl.br_cond = rv32_pkg::BR_NONE;
        endcase
      end
      rv32_pkg::OPC_LOAD: begin
        // Word access only, address is rs1 + imm
        ctrl.mem_read = 1'b1;
        ctrl.rd_write = 1'b1;
        ctrl.wb_src   = rv32_pkg::WB_LOAD;
      end
      rv32_pkg::OPC_STORE: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/rv32_execute.sv
/*
 * Execute stage
 * Operand select, ALU, branch compare and redirect target
 */
module rv32_execute (
  rv32_ctrl_if.exe        ctrl,
  input  rv32_pkg::word_t pc_i,
  input  rv32_pkg::word_t rs1_data_i,
  input  rv32_pkg::word_t rs2_data_i,
  output rv32_pkg::word_t alu_result_o,
  output logic            redirect_o,
  output rv32_pkg::word_t redirect_pc_o
);

  rv32_pkg::word_t op_a;
  rv32_pkg::word_t op_b;
  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic            eq;
  rv32_pkg::word_t jalr_sum;

  // Operand muxes
  assign op_a  = ctrl.op_a_is_pc ? pc_i : rs1_data_i;
  assign op_b  = ctrl.op_b_is_imm ? ctrl.imm : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv32_pkg::ALU_ADD:    alu_result_o = op_a + op_b;
      rv32_pkg::ALU_SUB:    alu_result_o = op_a - op_b;
      rv32_pkg::ALU_SLL:    alu_result_o = op_a << shamt;
      rv32_pkg::ALU_SLT:    alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
      rv32_pkg::ALU_SLTU:   alu_result_o = {31'b0, op_a < op_b};
      rv32_pkg::ALU_XOR:    alu_result_o = op_a ^ op_b;
      rv32_pkg::ALU_SRL:    alu_result_o = op_a >> shamt;
      rv32_pkg::ALU_SRA:    alu_result_o = $signed(op_a) >>> shamt;
      rv32_pkg::ALU_OR:     alu_result_o = op_a | op_b;
      rv32_pkg::ALU_AND:    alu_result_o = op_a & op_b;
      rv32_pkg::ALU_PASS_B: alu_result_o = op_b;
      default:              alu_result_o = op_a + op_b;
    endcase
  end

  // Branch compare always on the register values
  assign eq   = (rs1_data_i == rs2_data_i);
  assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign lt_u = (rs1_data_i < rs2_data_i);

  always_comb begin
    case (ctrl.br_cond)
      rv32_pkg::BR_EQ:     redirect_o = eq;
      rv32_pkg::BR_NE:     redirect_o = !eq;
      rv32_pkg::BR_LT:     redirect_o = lt_s;
      rv32_pkg::BR_GE:     redirect_o = !lt_s;
      rv32_pkg::BR_LTU:    redirect_o = lt_u;
      rv32_pkg::BR_GEU:    redirect_o = !lt_u;
      rv32_pkg::BR_ALWAYS: redirect_o = 1'b1;
      default:             redirect_o = 1'b0;
    endcase
  end

  // JALR clears bit 0 of the sum
  assign jalr_sum      = rs1_data_i + ctrl.imm;
  assign redirect_pc_o = ctrl.is_jalr ? {jalr_sum[31:1], 1'b0} : pc_i + ctrl.imm;

endmodule

// File: hdl/rv32_fetch.sv
/*
 * Instruction fetch
 * Program counter, request FSM and instruction holding register
 */
module rv32_fetch #(
  parameter rv32_pkg::word_t INITIAL_PC = '0
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            retire_i,
  input  logic            redirect_i,
  input  rv32_pkg::word_t redirect_pc_i,
  output logic            instr_req_o,
  output rv32_pkg::word_t instr_addr_o,
  input  logic            instr_ack_i,
  input  rv32_pkg::word_t instr_data_i,
  output rv32_pkg::word_t pc_o,
  output rv32_pkg::word_t pc_next_o,
  output rv32_pkg::word_t instr_o,
  output logic            instr_valid_o
);

  // Idle only right after reset
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_HOLD
  } fetch_state_t;

  fetch_state_t    state;
  rv32_pkg::word_t pc;
  rv32_pkg::word_t instr_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= ST_IDLE;
      pc      <= INITIAL_PC;
      instr_q <= rv32_pkg::NOP_INSTR;
    end else begin
      case (state)
        ST_IDLE: state <= ST_REQ;
        ST_REQ: begin
          // Capture on ack, present until retire
          if (instr_ack_i) begin
            instr_q <= instr_data_i;
            state   <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (retire_i) begin
            pc    <= redirect_i ? redirect_pc_i : pc_next_o;
            state <= ST_REQ;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign instr_req_o   = (state == ST_REQ);
  assign instr_addr_o  = pc;
  assign instr_valid_o = (state == ST_HOLD);
  assign instr_o       = instr_q;
  assign pc_o          = pc;
  // Sequential successor, also the link value
  assign pc_next_o     = pc + 32'd4;

endmodule

// File: hdl/rv32_lsu.sv
/*
 * Load/store unit
 * Data bus requester, load data capture and stall
 */
module rv32_lsu (
  input  logic            clk,
  input  logic            reset,
  rv32_ctrl_if.lsu        ctrl,
  input  logic            instr_valid_i,
  input  rv32_pkg::word_t addr_i,
  input  rv32_pkg::word_t wdata_i,
  output logic            stall_o,
  output rv32_pkg::word_t load_data_o,
  output logic            data_req_o,
  output logic            data_we_o,
  output rv32_pkg::word_t data_addr_o,
  output rv32_pkg::word_t data_wdata_o,
  input  logic            data_ack_i,
  input  rv32_pkg::word_t data_rdata_i
);

  logic done;
  logic pending;

  // Valid memory instruction not yet acknowledged
  assign pending = instr_valid_i && (ctrl.mem_read || ctrl.mem_write) && !done;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done <= 1'b0;
    end else if (pending && data_ack_i) begin
      done <= 1'b1;
    end else if (done) begin
      // Instruction retires in this cycle
      done <= 1'b0;
    end
  end

  // Read data captured on ack
  always_ff @(posedge clk) begin
    if (pending && data_ack_i) begin
      load_data_o <= data_rdata_i;
    end
  end

  // Core holds through the whole request
  assign stall_o      = pending;
  assign data_req_o   = pending;
  assign data_we_o    = pending && ctrl.mem_write;
  assign data_addr_o  = addr_i;
  assign data_wdata_o = wdata_i;

endmodule

// File: hdl/rv32_pkg.sv
/*
 * Shared definitions for the RV32I core
 * Widths, word and register index types
 * Opcode, ALU, branch and write-back encodings
 */
package rv32_pkg;

  // Data and address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // Operand B straight through, for LUI
    ALU_PASS_B
  } alu_op_t;

  // Branch conditions, ALWAYS for JAL and JALR
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_ALWAYS
  } br_cond_t;

  // Write-back sources
  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC_NEXT,
    WB_LOAD
  } wb_src_t;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: hdl/rv32_regfile.sv
/*
 * Register file, 32 x 32 bits
 * Two combinational read ports, one write port, x0 fixed at zero
 */
module rv32_regfile (
  input  logic               clk,
  input  logic               reset,
  input  rv32_pkg::reg_idx_t rs1_i,
  input  rv32_pkg::reg_idx_t rs2_i,
  output rv32_pkg::word_t    rs1_data_o,
  output rv32_pkg::word_t    rs2_data_o,
  input  rv32_pkg::reg_idx_t rd_i,
  input  rv32_pkg::word_t    rd_data_i,
  input  logic               rd_we_i
);

  rv32_pkg::word_t regs [32];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // Whole file starts at zero
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module rv32_core_tb -f rv32_core.f -o rv32_core_sim || exit 1

./obj_dir/rv32_core_sim > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: rv32_core.f
hdl/rv32_pkg.sv
hdl/rv32_ctrl_if.sv
hdl/rv32_fetch.sv
hdl/rv32_decoder.sv
hdl/rv32_regfile.sv
hdl/rv32_execute.sv
hdl/rv32_lsu.sv
hdl/rv32_core.sv
test/rv32_core_assertions.sv
test/rv32_core_tb.sv

// File: test/rv32_core_assertions.sv
/*
 * Bus protocol assertions for the RV32I core
 * Request stability, single open request, aligned data address
 */
module rv32_core_assertions (
  input logic        clk,
  input logic        reset,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        instr_ack_i,
  input logic        data_req_o,
  input logic [31:0] data_addr_o,
  input logic        data_ack_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Waiting instruction request keeps its address
  instr_hold: assert property (@(posedge clk) disable iff (reset)
    (instr_req_o && !instr_ack_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("instruction request dropped or address moved before ack");

  // Waiting data request keeps its address
  data_hold: assert property (@(posedge clk) disable iff (reset)
    (data_req_o && !data_ack_i) |=> (data_req_o && $stable(data_addr_o)))
    else $error("data request dropped or address moved before ack");

  // One open request at a time
  one_request: assert property (@(posedge clk) disable iff (reset)
    !(instr_req_o && data_req_o))
    else $error("instruction and data requests open together");

  // Word accesses only
  data_aligned: assert property (@(posedge clk) disable iff (reset)
    data_req_o |-> (data_addr_o[1:0] == 2'b00))
    else $error("data address not word aligned");

endmodule

bind rv32_core rv32_core_assertions u_assertions (
  .clk(clk), .reset(reset),
  .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_ack_i(instr_ack_i),
  .data_req_o(data_req_o), .data_addr_o(data_addr_o), .data_ack_i(data_ack_i)
);

// File: test/rv32_core_tb.sv
/*
 * Testbench for the RV32I core
 * Instruction and data memory models with random ack delay
 * Program table, per-test loop, store checks and report
 */
module rv32_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS    = 5;
  localparam int TEST_CYCLES  = 300;
  localparam int RESET_CYCLES = 10;
  localparam int CYCLE_LIMIT  = NUM_TESTS * (TEST_CYCLES + RESET_CYCLES + 4);

  // RV32I major opcodes
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_AUI = 7'b0010111;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JLR = 7'b1100111;
  localparam logic [6:0] OP_BR  = 7'b1100011;
  localparam logic [6:0] OP_LD  = 7'b0000011;
  localparam logic [6:0] OP_ST  = 7'b0100011;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_ack = 1'b0;
  logic [31:0] instr_rdata = '0;
  logic        data_req;
  logic        data_we;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_ack = 1'b0;
  logic [31:0] data_rdata = '0;

  // Test table
  string       names [NUM_TESTS];
  logic [31:0] progs [NUM_TESTS][16];
  logic [31:0] preload [NUM_TESTS];
  logic [31:0] exp_addr [NUM_TESTS];
  logic [31:0] exp_data [NUM_TESTS];

  // Memory images, copied into the models during reset
  logic [31:0] imem_init [64];
  logic [31:0] dmem_init [16];
  logic [31:0] imem [64];
  logic [31:0] dmem [16];

  integer      seed = 67332;
  logic [1:0]  i_delay = 2'd0;
  logic [1:0]  i_wait = 2'd0;
  logic [1:0]  d_delay = 2'd0;
  logic [1:0]  d_wait = 2'd0;
  logic        store_seen = 1'b0;
  logic [31:0] store_addr = '0;
  logic [31:0] store_data = '0;
  int          cycle_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;

  rv32_core #(.INITIAL_PC(32'h0)) u_rv32_core (
    .clk(clk), .reset(reset),
    .instr_req_o(instr_req), .instr_addr_o(instr_addr),
    .instr_ack_i(instr_ack), .instr_data_i(instr_rdata),
    .data_req_o(data_req), .data_we_o(data_we),
    .data_addr_o(data_addr), .data_wdata_o(data_wdata),
    .data_ack_i(data_ack), .data_rdata_i(data_rdata)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // Instruction encoders, straight from the ISA formats
  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd,
                                        logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_ST};
  endfunction

  function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BR};
  endfunction

  function automatic logic [31:0] enc_u(int imm20, int rd, logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  task automatic build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      // Unused slots hold addi x0, x0, index
      for (int i = 0; i < 16; i++) begin
        progs[t][i] = enc_i(i, 0, 0, 0, OP_IMM);
      end
      preload[t] = 32'h0;
    end
    // ALU ops, stored x6 = (107 ^ -7) >>> slt
    names[0] = "alu_ops";
    progs[0][0] = enc_i(100, 0, 0, 1, OP_IMM);
    progs[0][1] = enc_i(-7, 0, 0, 2, OP_IMM);
    progs[0][2] = enc_r(32, 2, 1, 0, 3);
    progs[0][3] = enc_r(0, 2, 3, 4, 4);
    progs[0][4] = enc_r(0, 1, 2, 2, 5);
    progs[0][5] = enc_r(32, 5, 4, 5, 6);
    progs[0][6] = enc_s(32, 6, 0);
    progs[0][7] = enc_j(0, 0);
    exp_addr[0] = 32'h20;
    exp_data[0] = 32'hFFFF_FFC9;
    // Upper immediates, AUIPC at PC 4
    names[1] = "lui_auipc";
    progs[1][0] = enc_u(20'h12345, 1, OP_LUI);
    progs[1][1] = enc_u(20'h00001, 2, OP_AUI);
    progs[1][2] = enc_r(0, 2, 1, 0, 3);
    progs[1][3] = enc_s(36, 3, 0);
    progs[1][4] = enc_j(0, 0);
    exp_addr[1] = 32'h24;
    exp_data[1] = 32'h1234_6004;
    // Branches, markers 1, 2 and 4 on the right path
    names[2] = "branches";
    progs[2][0]  = enc_i(5, 0, 0, 1, OP_IMM);
    progs[2][1]  = enc_i(-3, 0, 0, 2, OP_IMM);
    progs[2][2]  = enc_i(0, 0, 0, 10, OP_IMM);
    progs[2][3]  = enc_b(8, 1, 1, 0);
    progs[2][4]  = enc_i(100, 10, 0, 10, OP_IMM);
    progs[2][5]  = enc_i(1, 10, 0, 10, OP_IMM);
    progs[2][6]  = enc_b(8, 1, 1, 1);
    progs[2][7]  = enc_i(2, 10, 0, 10, OP_IMM);
    progs[2][8]  = enc_b(8, 1, 2, 4);
    progs[2][9]  = enc_i(100, 10, 0, 10, OP_IMM);
    progs[2][10] = enc_b(8, 2, 1, 7);
    progs[2][11] = enc_i(4, 10, 0, 10, OP_IMM);
    progs[2][12] = enc_s(40, 10, 0);
    progs[2][13] = enc_j(0, 0);
    exp_addr[2] = 32'h28;
    exp_data[2] = 32'd7;
    // Jumps, ((8 + 24) << 4) + 3
    names[3] = "jal_jalr";
    progs[3][0]  = enc_i(0, 0, 0, 10, OP_IMM);
    progs[3][1]  = enc_j(12, 1);
    progs[3][2]  = enc_i(100, 10, 0, 10, OP_IMM);
    progs[3][3]  = enc_i(100, 10, 0, 10, OP_IMM);
    progs[3][4]  = enc_i(1, 10, 0, 10, OP_IMM);
    progs[3][5]  = enc_i(21, 1, 0, 5, OP_JLR);
    progs[3][6]  = enc_i(100, 10, 0, 10, OP_IMM);
    progs[3][7]  = enc_i(2, 10, 0, 10, OP_IMM);
    progs[3][8]  = enc_r(0, 5, 1, 0, 11);
    progs[3][9]  = enc_i(4, 11, 1, 11, OP_IMM);
    progs[3][10] = enc_r(0, 10, 11, 0, 12);
    progs[3][11] = enc_s(44, 12, 0);
    progs[3][12] = enc_j(0, 0);
    exp_addr[3] = 32'h2C;
    exp_data[3] = 32'd515;
    // Load, modify, store back, x0 stays zero
    names[4] = "load_store";
    progs[4][0] = enc_i(16, 0, 2, 1, OP_LD);
    progs[4][1] = enc_i(5, 1, 0, 1, OP_IMM);
    progs[4][2] = enc_i(77, 0, 0, 0, OP_IMM);
    progs[4][3] = enc_r(0, 0, 1, 0, 2);
    progs[4][4] = enc_s(48, 2, 0);
    progs[4][5] = enc_j(0, 0);
    preload[4]  = 32'h0000_1230;
    exp_addr[4] = 32'h30;
    exp_data[4] = 32'h0000_1235;
  endtask

  // Memory models and store capture, one random stream
  always @(posedge clk) begin : mem_models
    logic [31:0] rnd;
    if (reset) begin
      instr_ack  <= 1'b0;
      data_ack   <= 1'b0;
      i_wait     <= 2'd0;
      d_wait     <= 2'd0;
      store_seen <= 1'b0;
      for (int i = 0; i < 64; i++) begin
        imem[i] <= imem_init[i];
      end
      for (int i = 0; i < 16; i++) begin
        dmem[i] <= dmem_init[i];
      end
    end else begin
      // Ack lasts one cycle
      if (instr_ack) begin
        instr_ack <= 1'b0;
      end else if (instr_req) begin
        if (i_wait >= i_delay) begin
          instr_ack   <= 1'b1;
          instr_rdata <= imem[instr_addr[7:2]];
          i_wait      <= 2'd0;
          rnd = $random(seed);
          i_delay     <= rnd[1:0];
        end else begin
          i_wait <= i_wait + 2'd1;
        end
      end
      if (data_ack) begin
        data_ack <= 1'b0;
      end else if (data_req) begin
        if (d_wait >= d_delay) begin
          data_ack   <= 1'b1;
          data_rdata <= dmem[data_addr[5:2]];
          d_wait     <= 2'd0;
          rnd = $random(seed);
          d_delay    <= rnd[1:0];
          if (data_we) begin
            dmem[data_addr[5:2]] <= data_wdata;
          end
          // First store of the program is the result
          if (data_we && !store_seen) begin
            store_seen <= 1'b1;
            store_addr <= data_addr;
            store_data <= data_wdata;
          end
        end else begin
          d_wait <= d_wait + 2'd1;
        end
      end
    end
  end

  // Run limit over all tests
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles, cycle limit reached", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int cyc;
    bit test_ok;
    build_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < 64; i++) begin
        imem_init[i] = (i < 16) ? progs[t][i] : enc_i(i, 0, 0, 0, OP_IMM);
      end
      // Data fill marks each word with its index
      for (int i = 0; i < 16; i++) begin
        dmem_init[i] = 32'hD000_0000 | i;
      end
      dmem_init[4] = preload[t];
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      cyc = 0;
      test_ok = 1'b1;
      while (!store_seen && cyc < TEST_CYCLES) begin
        @(negedge clk);
        cyc++;
      end
      assert (store_seen) else begin
        $display("test %s: no store within %0d cycles", names[t], TEST_CYCLES);
        test_ok = 1'b0;
      end
      if (store_seen) begin
        assert (store_addr == exp_addr[t]) else begin
          $display("[FAIL] %s address expected %h actual %h",
                   names[t], exp_addr[t], store_addr);
          test_ok = 1'b0;
        end
        assert (store_data == exp_data[t]) else begin
          $display("[FAIL] %s data expected %h actual %h",
                   names[t], exp_data[t], store_data);
          test_ok = 1'b0;
        end
      end
      if (test_ok) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("test %0d %s: %s", t, names[t], test_ok ? "ok" : "wrong result");
    end
    $display("%0d of %0d tests passed, %0d failed", pass_count, NUM_TESTS, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
